/* compile.f */
hw/rp_pkg.sv
hw/sys_bus_if.sv
hw/sys_bus_decoder.sv
hw/housekeeping.sv
hw/adc_frontend.sv
hw/level_gen.sv
hw/p_controller.sv
hw/dac_backend.sv
hw/rp_top.sv
tb/rp_props.sv
tb/rp_tb.sv

/* hw/adc_frontend.sv */
//--------------------------------------------------------------------------
// ADC front end
// registers the raw codes as two's complement samples, or the DAC sums
// when digital loopback is on
//--------------------------------------------------------------------------
`timescale 1ns/1ns

module adc_frontend import rp_pkg::*; (
  input  logic      adc_clk,
  input  logic      rst_n_i,
  input  dac_code_t adc_dat_a_i,     // raw pin code ch a
  input  dac_code_t adc_dat_b_i,     // raw pin code ch b
  input  sample_t   dac_a_i,         // saturated dac sum ch a
  input  sample_t   dac_b_i,
  input  logic      digital_loop_i,
  output sample_t   adc_a_o,
  output sample_t   adc_b_o
);

  sample_t adc_a_q;
  sample_t adc_b_q;

  // one register stage, also breaks the loopback path
  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      adc_a_q <= '0;
      adc_b_q <= '0;
    end else begin
      adc_a_q <= digital_loop_i ? dac_a_i : sample_t'(slope_flip(adc_dat_a_i));
      adc_b_q <= digital_loop_i ? dac_b_i : sample_t'(slope_flip(adc_dat_b_i));
    end
  end

  assign adc_a_o = adc_a_q;
  assign adc_b_o = adc_b_q;

endmodule

/* hw/dac_backend.sv */
//--------------------------------------------------------------------------
// DAC back end
// level + controller at 15 bits, clamp to 14, back to negative slope
//--------------------------------------------------------------------------
`timescale 1ns/1ns

module dac_backend import rp_pkg::*; (
  input  logic      adc_clk,
  input  logic      rst_n_i,
  input  sample_t   lvl_a_i,
  input  sample_t   lvl_b_i,
  input  sample_t   pid_a_i,
  input  sample_t   pid_b_i,
  output sample_t   dac_a_o,       // saturated sums, also for loopback
  output sample_t   dac_b_o,
  output dac_code_t dac_dat_a_o,
  output dac_code_t dac_dat_b_o
);

  logic signed [ADC_W:0] sum_a;    // one guard bit
  logic signed [ADC_W:0] sum_b;
  dac_code_t             dac_a_q;
  dac_code_t             dac_b_q;

  assign sum_a   = lvl_a_i + pid_a_i;
  assign sum_b   = lvl_b_i + pid_b_i;
  assign dac_a_o = sat_sample(SYS_DW'(sum_a));
  assign dac_b_o = sat_sample(SYS_DW'(sum_b));

  // output register, mid-scale code out of reset
  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      dac_a_q <= slope_flip(ADC_W'(0));
      dac_b_q <= slope_flip(ADC_W'(0));
    end else begin
      dac_a_q <= slope_flip(dac_a_o);
      dac_b_q <= slope_flip(dac_b_o);
    end
  end

  assign dac_dat_a_o = dac_a_q;
  assign dac_dat_b_o = dac_b_q;

endmodule

/* hw/housekeeping.sv */
//--------------------------------------------------------------------------
// housekeeping registers (region 0)
// read-only design id, LED register and the digital loopback bit
//--------------------------------------------------------------------------
`timescale 1ns/1ns

module housekeeping import rp_pkg::*; #(
  parameter sys_word_t HK_ID = 32'h5250_0001
) (
  input  logic       adc_clk,
  input  logic       rst_n_i,
  sys_bus_if.slave   bus,
  output logic [7:0] led_o,
  output logic       digital_loop_o
);

  logic [REGION_LSB-1:0] off;       // offset inside the region
  logic [7:0]            led_q;
  logic                  loop_q;
  logic                  ack_q;
  sys_word_t             rdata_q;

  assign off = bus.addr[REGION_LSB-1:0];

  // control registers and ack
  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      led_q  <= '0;
      loop_q <= 1'b0;
      ack_q  <= 1'b0;
    end else begin
      ack_q <= bus.wen | bus.ren;
      if (bus.wen) begin
        case (off)
          REG_HK_LOOP: loop_q <= bus.wdata[0];
          REG_HK_LED:  led_q  <= bus.wdata[7:0];
          default: ;                          // id and holes ignore writes
        endcase
      end
    end
  end

  // read mux, sampled on the read strobe
  always_ff @(posedge adc_clk) begin
    if (bus.ren) begin
      case (off)
        REG_HK_ID:   rdata_q <= HK_ID;
        REG_HK_LOOP: rdata_q <= SYS_DW'(loop_q);
        REG_HK_LED:  rdata_q <= SYS_DW'(led_q);
        default:     rdata_q <= '0;
      endcase
    end
  end

  assign bus.ack        = ack_q;
  assign bus.rdata      = rdata_q;
  assign led_o          = led_q;
  assign digital_loop_o = loop_q;

endmodule

/* hw/level_gen.sv */
//--------------------------------------------------------------------------
// DC level generator (region 2)
// one signed level per channel, written and read over the bus
//--------------------------------------------------------------------------
`timescale 1ns/1ns

module level_gen import rp_pkg::*; (
  input  logic     adc_clk,
  input  logic     rst_n_i,
  sys_bus_if.slave bus,
  output sample_t  lvl_a_o,
  output sample_t  lvl_b_o
);

  logic [REGION_LSB-1:0] off;
  sample_t               lvl_a_q;
  sample_t               lvl_b_q;
  logic                  ack_q;
  sys_word_t             rdata_q;

  assign off = bus.addr[REGION_LSB-1:0];

  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      lvl_a_q <= '0;
      lvl_b_q <= '0;
      ack_q   <= 1'b0;
    end else begin
      ack_q <= bus.wen | bus.ren;
      if (bus.wen) begin
        case (off)
          REG_LVL_A: lvl_a_q <= bus.wdata[ADC_W-1:0];   // low 14 bits only
          REG_LVL_B: lvl_b_q <= bus.wdata[ADC_W-1:0];
          default: ;
        endcase
      end
    end
  end

  // readback sign extended to bus width
  always_ff @(posedge adc_clk) begin
    if (bus.ren) begin
      case (off)
        REG_LVL_A: rdata_q <= SYS_DW'(lvl_a_q);
        REG_LVL_B: rdata_q <= SYS_DW'(lvl_b_q);
        default:   rdata_q <= '0;
      endcase
    end
  end

  assign bus.ack   = ack_q;
  assign bus.rdata = rdata_q;
  assign lvl_a_o   = lvl_a_q;
  assign lvl_b_o   = lvl_b_q;

endmodule

/* hw/p_controller.sv */
//--------------------------------------------------------------------------
// proportional controller (region 3)
// per channel: out = sat((sp - sample) * kp >>> PID_SHIFT)
// stage 1 registers the error and the gain, stage 2 the clamped product
//--------------------------------------------------------------------------
`timescale 1ns/1ns

module p_controller import rp_pkg::*; #(
  parameter int unsigned PID_SHIFT = 8
) (
  input  logic     adc_clk,
  input  logic     rst_n_i,
  input  sample_t  adc_a_i,
  input  sample_t  adc_b_i,
  sys_bus_if.slave bus,
  output sample_t  pid_a_o,
  output sample_t  pid_b_o
);

  localparam int CH_N  = 2;
  localparam int ERR_W = ADC_W + 1;   // sp - sample never overflows here

  logic [REGION_LSB-1:0]    off;
  sample_t                  sp_q   [CH_N];   // setpoints
  sample_t                  kp_q   [CH_N];   // gains, signed
  sample_t                  smp    [CH_N];
  logic signed [ERR_W-1:0]  err_q  [CH_N];   // stage 1
  sample_t                  kp_p_q [CH_N];   // gain aligned with err_q
  logic signed [SYS_DW-1:0] prod   [CH_N];   // shifted product, 29 bits used
  sample_t                  pid_q  [CH_N];   // stage 2
  logic                     ack_q;
  sys_word_t                rdata_q;

  assign off    = bus.addr[REGION_LSB-1:0];
  assign smp[0] = adc_a_i;
  assign smp[1] = adc_b_i;

  //--------------------------------------------------------------------------
  // register file
  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sp_q  <= '{default: '0};
      kp_q  <= '{default: '0};
      ack_q <= 1'b0;
    end else begin
      ack_q <= bus.wen | bus.ren;
      if (bus.wen) begin
        case (off)
          REG_SP_A: sp_q[0] <= bus.wdata[ADC_W-1:0];
          REG_KP_A: kp_q[0] <= bus.wdata[ADC_W-1:0];
          REG_SP_B: sp_q[1] <= bus.wdata[ADC_W-1:0];
          REG_KP_B: kp_q[1] <= bus.wdata[ADC_W-1:0];
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge adc_clk) begin
    if (bus.ren) begin
      case (off)
        REG_SP_A: rdata_q <= SYS_DW'(sp_q[0]);   // sign extended
        REG_KP_A: rdata_q <= SYS_DW'(kp_q[0]);
        REG_SP_B: rdata_q <= SYS_DW'(sp_q[1]);
        REG_KP_B: rdata_q <= SYS_DW'(kp_q[1]);
        default:  rdata_q <= '0;
      endcase
    end
  end

  //--------------------------------------------------------------------------
  // datapath, two samples in flight
  always_comb begin
    for (int c = 0; c < CH_N; c++) begin
      prod[c] = (err_q[c] * kp_p_q[c]) >>> PID_SHIFT;   // arithmetic shift
    end
  end

  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      err_q  <= '{default: '0};
      kp_p_q <= '{default: '0};
      pid_q  <= '{default: '0};
    end else begin
      for (int c = 0; c < CH_N; c++) begin
        err_q[c]  <= sp_q[c] - smp[c];
        kp_p_q[c] <= kp_q[c];
        pid_q[c]  <= sat_sample(prod[c]);
      end
    end
  end

  assign bus.ack   = ack_q;
  assign bus.rdata = rdata_q;
  assign pid_a_o   = pid_q[0];
  assign pid_b_o   = pid_q[1];

endmodule

/* hw/rp_pkg.sv */
//--------------------------------------------------------------------------
// shared definitions for the two-channel analog core
// widths, bus region map, register offsets, sample types
// plus the slope conversion and saturation helpers
//--------------------------------------------------------------------------
package rp_pkg;

  localparam int unsigned ADC_W      = 14;   // converter resolution
  localparam int unsigned SYS_AW     = 32;
  localparam int unsigned SYS_DW     = 32;
  localparam int unsigned REGION_N   = 8;
  localparam int unsigned REGION_LSB = 20;   // region field is addr[22:20]

  localparam int SAMPLE_MAX = 2**(ADC_W-1) - 1;
  localparam int SAMPLE_MIN = -(2**(ADC_W-1));

  typedef logic signed [ADC_W-1:0]  sample_t;    // two's complement
  typedef logic        [ADC_W-1:0]  dac_code_t;  // pin code, negative slope
  typedef logic        [SYS_DW-1:0] sys_word_t;
  typedef logic        [2:0]        region_t;

  // region map
  localparam region_t REGION_HK  = 3'd0;
  localparam region_t REGION_LVL = 3'd2;
  localparam region_t REGION_PID = 3'd3;

  // housekeeping
  localparam logic [REGION_LSB-1:0] REG_HK_ID   = 'h00;
  localparam logic [REGION_LSB-1:0] REG_HK_LOOP = 'h04;
  localparam logic [REGION_LSB-1:0] REG_HK_LED  = 'h30;
  // level generator
  localparam logic [REGION_LSB-1:0] REG_LVL_A   = 'h00;
  localparam logic [REGION_LSB-1:0] REG_LVL_B   = 'h04;
  // proportional controller
  localparam logic [REGION_LSB-1:0] REG_SP_A    = 'h00;
  localparam logic [REGION_LSB-1:0] REG_KP_A    = 'h04;
  localparam logic [REGION_LSB-1:0] REG_SP_B    = 'h08;
  localparam logic [REGION_LSB-1:0] REG_KP_B    = 'h0C;

  // msb kept, rest inverted; works in both directions
  function automatic logic [ADC_W-1:0] slope_flip(input logic [ADC_W-1:0] v);
    return {v[ADC_W-1], ~v[ADC_W-2:0]};
  endfunction

  // clamp a wide signed value into sample range
  function automatic sample_t sat_sample(input logic signed [SYS_DW-1:0] v);
    sample_t r;
    if (v > SAMPLE_MAX)      r = sample_t'(SAMPLE_MAX);
    else if (v < SAMPLE_MIN) r = sample_t'(SAMPLE_MIN);
    else                     r = v[ADC_W-1:0];
    return r;
  endfunction

endpackage

/* hw/rp_top.sv */
//--------------------------------------------------------------------------
// analog core top level
// bus decoder, housekeeping, ADC front end, level generator,
// proportional controller and DAC back end, all on adc_clk
//--------------------------------------------------------------------------
`timescale 1ns/1ns

module rp_top import rp_pkg::*; #(
  parameter sys_word_t   HK_ID     = 32'h5250_0001,
  parameter int unsigned PID_SHIFT = 8
) (
  input  logic              adc_clk,
  input  logic              rst_n_i,
  input  dac_code_t         adc_dat_a_i,
  input  dac_code_t         adc_dat_b_i,
  input  logic [SYS_AW-1:0] sys_addr_i,
  input  sys_word_t         sys_wdata_i,
  input  logic              sys_wen_i,
  input  logic              sys_ren_i,
  output sys_word_t         sys_rdata_o,
  output logic              sys_ack_o,
  output dac_code_t         dac_dat_a_o,
  output dac_code_t         dac_dat_b_o,
  output logic [7:0]        led_o
);

  sample_t adc_a, adc_b;     // registered samples
  sample_t lvl_a, lvl_b;
  sample_t pid_a, pid_b;
  sample_t dac_a, dac_b;     // saturated sums back to the front end
  logic    digital_loop;

  sys_bus_if hk_bus  ();
  sys_bus_if lvl_bus ();
  sys_bus_if pid_bus ();

  //--------------------------------------------------------------------------
  // bus
  sys_bus_decoder i_dec (
    .adc_clk     (adc_clk),
    .rst_n_i     (rst_n_i),
    .sys_addr_i  (sys_addr_i),
    .sys_wdata_i (sys_wdata_i),
    .sys_wen_i   (sys_wen_i),
    .sys_ren_i   (sys_ren_i),
    .sys_rdata_o (sys_rdata_o),
    .sys_ack_o   (sys_ack_o),
    .hk_bus      (hk_bus),
    .lvl_bus     (lvl_bus),
    .pid_bus     (pid_bus)
  );

  housekeeping #(.HK_ID(HK_ID)) i_hk (
    .adc_clk        (adc_clk),
    .rst_n_i        (rst_n_i),
    .bus            (hk_bus),
    .led_o          (led_o),
    .digital_loop_o (digital_loop)
  );

  //--------------------------------------------------------------------------
  // signal path
  adc_frontend i_adc (
    .adc_clk        (adc_clk),
    .rst_n_i        (rst_n_i),
    .adc_dat_a_i    (adc_dat_a_i),
    .adc_dat_b_i    (adc_dat_b_i),
    .dac_a_i        (dac_a),
    .dac_b_i        (dac_b),
    .digital_loop_i (digital_loop),
    .adc_a_o        (adc_a),
    .adc_b_o        (adc_b)
  );

  level_gen i_lvl (
    .adc_clk (adc_clk),
    .rst_n_i (rst_n_i),
    .bus     (lvl_bus),
    .lvl_a_o (lvl_a),
    .lvl_b_o (lvl_b)
  );

  p_controller #(.PID_SHIFT(PID_SHIFT)) i_pid (
    .adc_clk (adc_clk),
    .rst_n_i (rst_n_i),
    .adc_a_i (adc_a),
    .adc_b_i (adc_b),
    .bus     (pid_bus),
    .pid_a_o (pid_a),
    .pid_b_o (pid_b)
  );

  dac_backend i_dac (
    .adc_clk     (adc_clk),
    .rst_n_i     (rst_n_i),
    .lvl_a_i     (lvl_a),
    .lvl_b_i     (lvl_b),
    .pid_a_i     (pid_a),
    .pid_b_i     (pid_b),
    .dac_a_o     (dac_a),
    .dac_b_o     (dac_b),
    .dac_dat_a_o (dac_dat_a_o),
    .dac_dat_b_o (dac_dat_b_o)
  );

endmodule

/* hw/sys_bus_decoder.sv */
//--------------------------------------------------------------------------
// system bus decoder
// splits the bus into eight regions on addr[22:20], routes strobes to
// the three live slaves and answers the empty regions itself
//--------------------------------------------------------------------------
`timescale 1ns/1ns

module sys_bus_decoder import rp_pkg::*; (
  input  logic              adc_clk,
  input  logic              rst_n_i,
  input  logic [SYS_AW-1:0] sys_addr_i,
  input  sys_word_t         sys_wdata_i,
  input  logic              sys_wen_i,
  input  logic              sys_ren_i,
  output sys_word_t         sys_rdata_o,
  output logic              sys_ack_o,
  sys_bus_if.master         hk_bus,
  sys_bus_if.master         lvl_bus,
  sys_bus_if.master         pid_bus
);

  region_t             region;
  region_t             region_q;      // region of the pending access
  logic [REGION_N-1:0] cs;            // one-hot region select
  logic                strobe;
  logic                unused_hit;
  logic                unused_ack_q;

  assign region     = sys_addr_i[REGION_LSB +: $bits(region_t)];
  assign cs         = REGION_N'(1) << region;
  assign strobe     = sys_wen_i | sys_ren_i;
  assign unused_hit = ~(cs[REGION_HK] | cs[REGION_LVL] | cs[REGION_PID]);

  //--------------------------------------------------------------------------
  // strobe fan-out
  assign hk_bus.addr   = sys_addr_i;
  assign hk_bus.wdata  = sys_wdata_i;
  assign hk_bus.wen    = sys_wen_i & cs[REGION_HK];
  assign hk_bus.ren    = sys_ren_i & cs[REGION_HK];

  assign lvl_bus.addr  = sys_addr_i;
  assign lvl_bus.wdata = sys_wdata_i;
  assign lvl_bus.wen   = sys_wen_i & cs[REGION_LVL];
  assign lvl_bus.ren   = sys_ren_i & cs[REGION_LVL];

  assign pid_bus.addr  = sys_addr_i;
  assign pid_bus.wdata = sys_wdata_i;
  assign pid_bus.wen   = sys_wen_i & cs[REGION_PID];
  assign pid_bus.ren   = sys_ren_i & cs[REGION_PID];

  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      region_q     <= '0;
      unused_ack_q <= 1'b0;
    end else begin
      if (strobe)
        region_q <= region;                  // hold until next strobe
      unused_ack_q <= strobe & unused_hit;   // empty region acks itself
    end
  end

  //--------------------------------------------------------------------------
  // return path, picked by the registered region
  always_comb begin
    case (region_q)
      REGION_HK: begin
        sys_rdata_o = hk_bus.rdata;
        sys_ack_o   = hk_bus.ack;
      end
      REGION_LVL: begin
        sys_rdata_o = lvl_bus.rdata;
        sys_ack_o   = lvl_bus.ack;
      end
      REGION_PID: begin
        sys_rdata_o = pid_bus.rdata;
        sys_ack_o   = pid_bus.ack;
      end
      default: begin
        sys_rdata_o = '0;             // unused regions read zero
        sys_ack_o   = unused_ack_q;
      end
    endcase
  end

endmodule

/* hw/sys_bus_if.sv */
//--------------------------------------------------------------------------
// system bus between the region decoder and one slave
// one-cycle strobes out, registered ack and read data back
//--------------------------------------------------------------------------
`timescale 1ns/1ns

interface sys_bus_if import rp_pkg::*; ();

  logic [SYS_AW-1:0] addr;    // full byte address
  sys_word_t         wdata;
  logic              wen;     // one-cycle write strobe
  logic              ren;     // one-cycle read strobe
  sys_word_t         rdata;   // valid in the ack cycle
  logic              ack;     // one cycle after the strobe

  modport master (
    output addr, wdata, wen, ren,
    input  rdata, ack
  );

  modport slave (
    input  addr, wdata, wen, ren,
    output rdata, ack
  );

endinterface

/* run.sh */
#!/usr/bin/env bash
# build the analog core testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module rp_tb -f compile.f -o rp_sim \
  || { echo "verilator build failed"; exit 1; }

# an aborted run counts as a failure
./obj_dir/rp_sim > sim.log 2>&1 || echo "Regression failed" >> sim.log
cat sim.log

grep -q "Regression failed" sim.log && exit 1 || exit 0

/* tb/rp_props.sv */
//--------------------------------------------------------------------------
// bus and reset properties of the analog core
// bound into the top level
//--------------------------------------------------------------------------
`timescale 1ns/1ns

module rp_props import rp_pkg::*; (
  input logic      adc_clk,
  input logic      rst_n_i,
  input logic      wen_i,
  input logic      ren_i,
  input logic      ack_i,
  input dac_code_t dac_a_i,
  input dac_code_t dac_b_i
);

  logic strobe;

  assign strobe = wen_i | ren_i;

  // ack one cycle after every strobe
  ack_after_strobe: assert property (
    @(posedge adc_clk) disable iff (!rst_n_i) strobe |=> ack_i
  ) else $error("bus ack missing one cycle after a strobe");

  ack_has_strobe: assert property (
    @(posedge adc_clk) disable iff (!rst_n_i) ack_i |-> $past(strobe)
  ) else $error("bus ack without a strobe in the cycle before");

  ack_one_cycle: assert property (
    @(posedge adc_clk) disable iff (!rst_n_i) ack_i |=> !ack_i
  ) else $error("bus ack high on two cycles in a row");

  // pins sit at mid-scale for as long as reset is held
  dac_mid_in_reset: assert property (
    @(posedge adc_clk) !rst_n_i |=> (dac_a_i == 14'h1FFF && dac_b_i == 14'h1FFF)
  ) else $error("DAC pins not at mid-scale during reset");

endmodule

bind rp_top rp_props u_props (
  .adc_clk (adc_clk),
  .rst_n_i (rst_n_i),
  .wen_i   (sys_wen_i),
  .ren_i   (sys_ren_i),
  .ack_i   (sys_ack_o),
  .dac_a_i (dac_dat_a_o),
  .dac_b_i (dac_dat_b_o)
);

/* tb/rp_tb.sv */
//--------------------------------------------------------------------------
// testbench for the analog core
// clock, reset, bus access tasks, reference model and directed tests
// for reset state, registers, level path, P control and loopback
//--------------------------------------------------------------------------
`timescale 1ns/1ns

module rp_tb import rp_pkg::*; ();

  localparam sys_word_t   HK_ID     = 32'h5250_0001;
  localparam int unsigned PID_SHIFT = 8;
  localparam int          ACK_WAIT  = 16;   // cycles before an access is given up

  logic              adc_clk;
  logic              rst_n_i;
  dac_code_t         adc_dat_a_i;
  dac_code_t         adc_dat_b_i;
  logic [SYS_AW-1:0] sys_addr_i;
  sys_word_t         sys_wdata_i;
  logic              sys_wen_i;
  logic              sys_ren_i;
  sys_word_t         sys_rdata_o;
  logic              sys_ack_o;
  dac_code_t         dac_dat_a_o;
  dac_code_t         dac_dat_b_o;
  logic [7:0]        led_o;

  int unsigned n_checks;
  int unsigned n_errors;
  int unsigned n_timeouts;

  rp_top #(.HK_ID(HK_ID), .PID_SHIFT(PID_SHIFT)) dut0 (.*);

  initial adc_clk = 1'b0;
  always #5 adc_clk = ~adc_clk;   // 100 MHz

  //--------------------------------------------------------------------------
  // reference model
  // pin code and sample mirror each other around 8191
  function automatic dac_code_t code_of(input int s);
    return dac_code_t'(8191 - s);
  endfunction

  function automatic int sample_of(input dac_code_t c);
    return 8191 - int'(c);
  endfunction

  function automatic int clamp14(input int v);
    if (v > 8191)
      return 8191;
    if (v < -8192)
      return -8192;
    return v;
  endfunction

  function automatic int low14(input sys_word_t w);   // signed low 14 bits
    int v;
    v = int'(w[13:0]);
    if (w[13])
      v = v - 16384;
    return v;
  endfunction

  // expected pin code of one channel with loopback off
  function automatic dac_code_t expect_pin(input int lvl, input int sp, input int kp,
                                           input dac_code_t raw);
    int err;
    int pid;
    err = sp - sample_of(raw);
    pid = clamp14((err * kp) >>> PID_SHIFT);
    return code_of(clamp14(lvl + pid));
  endfunction

  function automatic int rand_sample();
    return int'($urandom_range(16383)) - 8192;
  endfunction

  function automatic logic [SYS_AW-1:0] addr_of(input region_t rg,
                                                input logic [REGION_LSB-1:0] off);
    return (SYS_AW'(rg) << REGION_LSB) | SYS_AW'(off);
  endfunction

  //--------------------------------------------------------------------------
  // compare tasks
  task automatic check_word(input string what, input sys_word_t got, input sys_word_t exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("FAILED @%0t: %s read %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_code(input string what, input dac_code_t got, input dac_code_t exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("FAILED @%0t: %s shows %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_led(input string what, input logic [7:0] got, input logic [7:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("FAILED @%0t: %s shows %h, expected %h", $time, what, got, exp);
    end
  endtask

  //--------------------------------------------------------------------------
  // one-cycle strobe then poll ack on the falling edge
  task automatic bus_access(input logic wr, input region_t rg,
                            input logic [REGION_LSB-1:0] off,
                            input sys_word_t wd, output sys_word_t rd);
    bit got;
    int n;
    got = 1'b0;
    rd  = '0;
    @(posedge adc_clk);
    sys_addr_i  <= addr_of(rg, off);
    sys_wdata_i <= wd;
    sys_wen_i   <= wr;
    sys_ren_i   <= ~wr;
    @(posedge adc_clk);
    sys_wen_i <= 1'b0;
    sys_ren_i <= 1'b0;
    for (n = 0; n < ACK_WAIT && !got; n++) begin
      @(negedge adc_clk);
      got = sys_ack_o;
      rd  = sys_rdata_o;   // valid in the ack cycle
    end
    if (!got) begin
      n_timeouts++;
      $display("no bus ack within %0d cycles for region %0d offset %h at %0t",
               ACK_WAIT, rg, off, $time);
    end
  endtask

  task automatic bus_write(input region_t rg, input logic [REGION_LSB-1:0] off,
                           input sys_word_t d);
    sys_word_t unused_rd;
    bus_access(1'b1, rg, off, d, unused_rd);
  endtask

  task automatic bus_read(input region_t rg, input logic [REGION_LSB-1:0] off,
                          output sys_word_t d);
    bus_access(1'b0, rg, off, '0, d);
  endtask

  task automatic drive_adc(input dac_code_t a, input dac_code_t b);
    @(posedge adc_clk);
    adc_dat_a_i <= a;
    adc_dat_b_i <= b;
  endtask

  task automatic set_pid(input int spa, input int kpa, input int spb, input int kpb);
    bus_write(REGION_PID, REG_SP_A, sys_word_t'(spa));
    bus_write(REGION_PID, REG_KP_A, sys_word_t'(kpa));
    bus_write(REGION_PID, REG_SP_B, sys_word_t'(spb));
    bus_write(REGION_PID, REG_KP_B, sys_word_t'(kpb));
  endtask

  task automatic settle(input int cycles);   // then sample mid-cycle
    repeat (cycles) @(posedge adc_clk);
    @(negedge adc_clk);
  endtask

  //--------------------------------------------------------------------------
  // directed tests
  task automatic reset_state();
    sys_word_t d;
    check_code("reset pin a", dac_dat_a_o, code_of(0));
    check_code("reset pin b", dac_dat_b_o, code_of(0));
    check_led("reset leds", led_o, 8'h00);
    bus_read(REGION_HK, REG_HK_ID, d);
    check_word("design id", d, HK_ID);
  endtask

  task automatic sext_roundtrip(input region_t rg, input logic [REGION_LSB-1:0] off,
                                input string what);
    sys_word_t w;
    sys_word_t d;
    for (int s = 0; s < 2; s++) begin
      w     = $urandom;                      // upper bits random, slave keeps 14
      w[13] = s[0];                          // positive then negative sample
      bus_write(rg, off, w);
      bus_read(rg, off, d);
      check_word(what, d, sys_word_t'(low14(w)));
    end
  endtask

  task automatic register_access();
    sys_word_t w;
    sys_word_t d;
    logic [REGION_LSB-1:0] off;
    w = $urandom;
    bus_write(REGION_HK, REG_HK_LED, w);
    check_led("led pins", led_o, w[7:0]);
    bus_read(REGION_HK, REG_HK_LED, d);
    check_word("led readback", d, {24'h0, w[7:0]});
    sext_roundtrip(REGION_LVL, REG_LVL_A, "level a");
    sext_roundtrip(REGION_LVL, REG_LVL_B, "level b");
    sext_roundtrip(REGION_PID, REG_SP_A, "setpoint a");
    sext_roundtrip(REGION_PID, REG_KP_A, "gain a");
    sext_roundtrip(REGION_PID, REG_SP_B, "setpoint b");
    sext_roundtrip(REGION_PID, REG_KP_B, "gain b");
    for (int r = 0; r < REGION_N; r++) begin
      if (r != REGION_HK && r != REGION_LVL && r != REGION_PID) begin
        off = REGION_LSB'($urandom_range(255) << 2);
        bus_read(region_t'(r), off, d);
        check_word("empty region", d, '0);
      end
    end
  endtask

  task automatic level_path();
    int la;
    int lb;
    set_pid(0, 0, 0, 0);
    for (int i = 0; i < 4; i++) begin
      la = rand_sample();
      lb = rand_sample();
      bus_write(REGION_LVL, REG_LVL_A, sys_word_t'(la));
      bus_write(REGION_LVL, REG_LVL_B, sys_word_t'(lb));
      settle(2);
      check_code("level pin a", dac_dat_a_o, code_of(la));
      check_code("level pin b", dac_dat_b_o, code_of(lb));
    end
    // full-scale level pushed past the rails by the controller
    drive_adc(code_of(0), code_of(0));
    bus_write(REGION_LVL, REG_LVL_A, sys_word_t'(8191));
    bus_write(REGION_LVL, REG_LVL_B, sys_word_t'(-8192));
    set_pid(4000, 256, -4000, 256);          // gain of one
    settle(6);
    check_code("upper clamp a", dac_dat_a_o, code_of(8191));
    check_code("lower clamp b", dac_dat_b_o, code_of(-8192));
  endtask

  task automatic prop_control();
    int spa;
    int kpa;
    int spb;
    int kpb;
    dac_code_t ra;
    dac_code_t rb;
    bus_write(REGION_HK, REG_HK_LOOP, '0);
    bus_write(REGION_LVL, REG_LVL_A, '0);
    bus_write(REGION_LVL, REG_LVL_B, '0);
    for (int i = 0; i < 8; i++) begin
      spa = rand_sample();
      spb = rand_sample();
      kpa = int'($urandom_range(1023)) - 512;   // mostly unsaturated
      kpb = int'($urandom_range(1023)) - 512;
      ra  = dac_code_t'($urandom);
      rb  = dac_code_t'($urandom);
      set_pid(spa, kpa, spb, kpb);
      drive_adc(ra, rb);
      settle(6);
      check_code("control pin a", dac_dat_a_o, expect_pin(0, spa, kpa, ra));
      check_code("control pin b", dac_dat_b_o, expect_pin(0, spb, kpb, rb));
    end
  endtask

  task automatic loopback_path();
    int la;
    int lb;
    int ka;
    int kb;
    dac_code_t ra;
    dac_code_t rb;
    la = int'($urandom_range(8000)) - 4000;
    lb = int'($urandom_range(8000)) - 4000;
    ka = int'($urandom_range(126)) + 1;     // loop gain below one
    kb = int'($urandom_range(126)) + 1;
    drive_adc(code_of(la), code_of(lb));    // zero error before closing the loop
    bus_write(REGION_LVL, REG_LVL_A, sys_word_t'(la));
    bus_write(REGION_LVL, REG_LVL_B, sys_word_t'(lb));
    set_pid(la, ka, lb, kb);
    settle(6);
    bus_write(REGION_HK, REG_HK_LOOP, 32'h1);
    for (int i = 0; i < 16; i++) begin
      drive_adc(dac_code_t'($urandom), dac_code_t'($urandom));
      @(negedge adc_clk);
      check_code("loopback pin a", dac_dat_a_o, code_of(la));
      check_code("loopback pin b", dac_dat_b_o, code_of(lb));
    end
    bus_write(REGION_HK, REG_HK_LOOP, '0);
    ra = dac_code_t'($urandom);
    rb = dac_code_t'($urandom);
    drive_adc(ra, rb);
    settle(6);
    check_code("open loop pin a", dac_dat_a_o, expect_pin(la, la, ka, ra));
    check_code("open loop pin b", dac_dat_b_o, expect_pin(lb, lb, kb, rb));
  endtask

  //--------------------------------------------------------------------------
  initial begin
    void'($urandom(32'h6978_8c29));
    n_checks    = 0;
    n_errors    = 0;
    n_timeouts  = 0;
    rst_n_i     <= 1'b0;
    adc_dat_a_i <= 14'h1FFF;   // mid-scale
    adc_dat_b_i <= 14'h1FFF;
    sys_addr_i  <= '0;
    sys_wdata_i <= '0;
    sys_wen_i   <= 1'b0;
    sys_ren_i   <= 1'b0;
    repeat (8) @(posedge adc_clk);
    rst_n_i <= 1'b1;
    @(negedge adc_clk);

    reset_state();
    register_access();
    level_path();
    prop_control();
    loopback_path();

    $display("checks %0d, errors %0d, timeouts %0d", n_checks, n_errors, n_timeouts);
    if (n_errors == 0 && n_timeouts == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule
